// File: icache_pkg.sv
package icache_pkg;

    // cache geometry
    localparam int WAYS       = 4;
    localparam int SETS       = 128;
    localparam int LINE_WORDS = 8;

    // address segments, top three bits
    localparam logic [2:0] SEG_KSEG0    = 3'b100;
    localparam logic [2:0] SEG_UNCACHED = 3'b101;

    // byte address and instruction word
    typedef logic [31:0] addr_t;
    typedef logic [31:0] word_t;

    // address fields
    // tag is addr[31:12], index addr[11:5], word offset addr[4:2]
    typedef logic [19:0] tag_t;
    typedef logic [6:0]  index_t;
    typedef logic [2:0]  offset_t;

    // way selects
    typedef logic [WAYS-1:0] way_mask_t;
    typedef logic [1:0]      way_idx_t;

    // read-address request
    typedef struct packed {
        addr_t      addr;
        logic [7:0] len;
    } ar_req_t;

    // one read-data beat
    typedef struct packed {
        word_t data;
        logic  last;
    } r_beat_t;

    // lookup and refill controller
    typedef enum logic [2:0] {
        idle,
        lookup,
        miss_req,
        miss_fill,
        uncached_req,
        uncached_wait,
        respond
    } ctrl_state_t;

endpackage

// File: icache_tag_array.sv
module icache_tag_array (
    input  logic                  clk,
    input  logic                  rst,
    input  icache_pkg::index_t    rd_index,
    input  icache_pkg::tag_t      lookup_tag,
    input  logic                  wr_en,
    input  icache_pkg::way_idx_t  wr_way,
    input  icache_pkg::index_t    wr_index,
    input  icache_pkg::tag_t      wr_tag,
    output icache_pkg::way_mask_t hit_way
);

    for (genvar w = 0; w < icache_pkg::WAYS; w++) begin : g_way
        icache_pkg::tag_t             tag_mem [icache_pkg::SETS];
        logic [icache_pkg::SETS-1:0]  valid;
        icache_pkg::tag_t             tag_q;
        logic                         valid_q;
        logic                         way_wr;

        assign way_wr = wr_en && (wr_way == icache_pkg::way_idx_t'(w));

        // tag storage, no reset
        always_ff @(posedge clk) begin
            if (way_wr) begin
                tag_mem[wr_index] <= wr_tag;
            end
            tag_q <= tag_mem[rd_index];
        end

        // valid bits, cleared by reset
        always_ff @(posedge clk) begin
            if (rst) begin
                valid   <= '0;
                valid_q <= 1'b0;
            end else begin
                if (way_wr) begin
                    valid[wr_index] <= 1'b1;
                end
                valid_q <= valid[rd_index];
            end
        end

        // compare in the cycle after the read
        assign hit_way[w] = valid_q && (tag_q == lookup_tag);
    end

endmodule

// File: icache_data_array.sv
module icache_data_array (
    input  logic                                     clk,
    input  icache_pkg::index_t                       rd_index,
    input  icache_pkg::offset_t                      rd_offset,
    input  logic                                     wr_en,
    input  icache_pkg::way_idx_t                     wr_way,
    input  icache_pkg::index_t                       wr_index,
    input  icache_pkg::offset_t                      wr_offset,
    input  icache_pkg::word_t                        wr_data,
    output icache_pkg::word_t [icache_pkg::WAYS-1:0] rd_word
);

    localparam int DEPTH = icache_pkg::SETS * icache_pkg::LINE_WORDS;
    localparam int AW    = $bits(icache_pkg::index_t) + $bits(icache_pkg::offset_t);

    logic [AW-1:0] rd_addr;
    logic [AW-1:0] wr_addr;

    // word address within one way
    assign rd_addr = {rd_index, rd_offset};
    assign wr_addr = {wr_index, wr_offset};

    for (genvar w = 0; w < icache_pkg::WAYS; w++) begin : g_way
        icache_pkg::word_t mem [DEPTH];
        logic              way_wr;

        assign way_wr = wr_en && (wr_way == icache_pkg::way_idx_t'(w));

        // one refill beat per write, all ways read together
        always_ff @(posedge clk) begin
            if (way_wr) begin
                mem[wr_addr] <= wr_data;
            end
            rd_word[w] <= mem[rd_addr];
        end
    end

endmodule

// File: icache_plru.sv
module icache_plru (
    input  logic                 clk,
    input  logic                 rst,
    input  icache_pkg::index_t   index,
    input  logic                 touch,
    input  icache_pkg::way_idx_t touch_way,
    output icache_pkg::way_idx_t victim
);

    // root picks the pair, leaf_lo/leaf_hi pick the way in pair 0/1
    logic [icache_pkg::SETS-1:0] root;
    logic [icache_pkg::SETS-1:0] leaf_lo;
    logic [icache_pkg::SETS-1:0] leaf_hi;

    icache_pkg::index_t index_q;

    // set captured with the array read, so it follows the lookup
    always_ff @(posedge clk) begin
        if (rst) begin
            index_q <= '0;
        end else begin
            index_q <= index;
        end
    end

    assign victim = root[index_q] ? {1'b1, leaf_hi[index_q]}
                                  : {1'b0, leaf_lo[index_q]};

    always_ff @(posedge clk) begin
        if (rst) begin
            root    <= '0;
            leaf_lo <= '0;
            leaf_hi <= '0;
        end else if (touch) begin
            // point away from the touched way
            root[index_q] <= ~touch_way[1];
            if (touch_way[1]) begin
                leaf_hi[index_q] <= ~touch_way[0];
            end else begin
                leaf_lo[index_q] <= ~touch_way[0];
            end
        end
    end

endmodule

// File: icache_ctrl.sv
module icache_ctrl (
    input  logic                                     clk,
    input  logic                                     rst,
    input  logic                                     fetch_req,
    input  icache_pkg::addr_t                        fetch_addr,
    output logic                                     fetch_ready,
    output logic                                     fetch_data_ok,
    output icache_pkg::word_t                        fetch_rdata,
    output icache_pkg::ar_req_t                      ar,
    output logic                                     ar_valid,
    input  logic                                     ar_ready,
    input  icache_pkg::r_beat_t                      r,
    input  logic                                     r_valid,
    output icache_pkg::index_t                       rd_index,
    output icache_pkg::offset_t                      rd_offset,
    output icache_pkg::tag_t                         lookup_tag,
    input  icache_pkg::way_mask_t                    hit_way,
    input  icache_pkg::word_t [icache_pkg::WAYS-1:0] way_words,
    input  icache_pkg::way_idx_t                     victim,
    output logic                                     touch,
    output icache_pkg::way_idx_t                     touch_way,
    output logic                                     tag_wr_en,
    output logic                                     data_wr_en,
    output icache_pkg::way_idx_t                     wr_way,
    output icache_pkg::offset_t                      wr_offset,
    output icache_pkg::word_t                        wr_data
);

    icache_pkg::ctrl_state_t state;
    icache_pkg::ctrl_state_t state_nxt;
    icache_pkg::ctrl_state_t accept_state;
    icache_pkg::addr_t       req_addr;
    icache_pkg::addr_t       bus_addr;
    icache_pkg::way_idx_t    victim_q;
    icache_pkg::way_idx_t    hit_idx;
    icache_pkg::offset_t     beat_cnt;
    icache_pkg::word_t       resp_word;
    icache_pkg::word_t       hit_word;
    logic                    hit;
    logic                    accept;
    logic                    next_cached;
    logic                    req_cached;
    logic                    fill_beat;

    assign hit         = |hit_way;
    assign fetch_ready = (state == icache_pkg::idle) || (state == icache_pkg::respond) ||
                         ((state == icache_pkg::lookup) && hit);
    assign accept      = fetch_req && fetch_ready;
    assign next_cached = fetch_addr[31:29] != icache_pkg::SEG_UNCACHED;
    assign req_cached  = req_addr[31:29] != icache_pkg::SEG_UNCACHED;
    assign fill_beat   = (state == icache_pkg::miss_fill) && r_valid;

    // where a newly accepted request goes
    assign accept_state = !accept    ? icache_pkg::idle :
                          next_cached ? icache_pkg::lookup : icache_pkg::uncached_req;

    always_comb begin
        state_nxt = state;
        unique case (state)
            icache_pkg::idle,
            icache_pkg::respond:       state_nxt = accept_state;
            icache_pkg::lookup:        state_nxt = hit ? accept_state : icache_pkg::miss_req;
            icache_pkg::miss_req:      if (ar_ready) state_nxt = icache_pkg::miss_fill;
            icache_pkg::miss_fill:     if (r_valid && r.last) state_nxt = icache_pkg::respond;
            icache_pkg::uncached_req:  if (ar_ready) state_nxt = icache_pkg::uncached_wait;
            icache_pkg::uncached_wait: if (r_valid) state_nxt = icache_pkg::respond;
            default:                   state_nxt = icache_pkg::idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= icache_pkg::idle;
            beat_cnt <= '0;
        end else begin
            state <= state_nxt;
            if (fill_beat) begin
                beat_cnt <= r.last ? '0 : icache_pkg::offset_t'(beat_cnt + 1'b1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_addr <= fetch_addr;
        end
        // victim frozen for the whole refill
        if ((state == icache_pkg::lookup) && !hit) begin
            victim_q <= victim;
        end
        if (fill_beat && (beat_cnt == req_addr[4:2])) begin
            resp_word <= r.data;
        end
        if ((state == icache_pkg::uncached_wait) && r_valid) begin
            resp_word <= r.data;
        end
    end

    // hit way select
    always_comb begin
        hit_idx  = '0;
        hit_word = '0;
        for (int w = 0; w < icache_pkg::WAYS; w++) begin
            if (hit_way[w]) begin
                hit_idx  = icache_pkg::way_idx_t'(w);
                hit_word = hit_word | way_words[w];
            end
        end
    end

    // arrays see the new address on the accept edge
    assign rd_index   = accept ? fetch_addr[11:5] : req_addr[11:5];
    assign rd_offset  = accept ? fetch_addr[4:2] : req_addr[4:2];
    assign lookup_tag = req_addr[31:12];

    assign fetch_data_ok = (state == icache_pkg::respond) || ((state == icache_pkg::lookup) && hit);
    assign fetch_rdata   = (state == icache_pkg::respond) ? resp_word : hit_word;

    // kseg0 and kseg1 both map to physical address 0
    assign bus_addr = ((req_addr[31:29] == icache_pkg::SEG_KSEG0) ||
                       (req_addr[31:29] == icache_pkg::SEG_UNCACHED)) ?
                      {3'b000, req_addr[28:0]} : req_addr;

    assign ar_valid = (state == icache_pkg::miss_req) || (state == icache_pkg::uncached_req);
    assign ar.addr  = (state == icache_pkg::miss_req) ? {bus_addr[31:5], 5'b00000} : bus_addr;
    assign ar.len   = (state == icache_pkg::miss_req) ? 8'(icache_pkg::LINE_WORDS - 1) : 8'd0;

    assign touch     = ((state == icache_pkg::lookup) && hit) ||
                       ((state == icache_pkg::respond) && req_cached);
    assign touch_way = (state == icache_pkg::lookup) ? hit_idx : victim_q;

    // tag goes in with the last beat
    assign data_wr_en = fill_beat;
    assign tag_wr_en  = fill_beat && r.last;
    assign wr_way     = victim_q;
    assign wr_offset  = beat_cnt;
    assign wr_data    = r.data;

endmodule

// File: icache_top.sv
module icache_top (
    input  logic                clk,
    input  logic                rst,
    input  logic                fetch_req,
    input  icache_pkg::addr_t   fetch_addr,
    output logic                fetch_ready,
    output logic                fetch_data_ok,
    output icache_pkg::word_t   fetch_rdata,
    output icache_pkg::ar_req_t ar,
    output logic                ar_valid,
    input  logic                ar_ready,
    input  icache_pkg::r_beat_t r,
    input  logic                r_valid
);

    icache_pkg::index_t                       rd_index;
    icache_pkg::offset_t                      rd_offset;
    icache_pkg::tag_t                         lookup_tag;
    icache_pkg::way_mask_t                    hit_way;
    icache_pkg::word_t [icache_pkg::WAYS-1:0] way_words;
    icache_pkg::way_idx_t                     victim;
    icache_pkg::way_idx_t                     touch_way;
    icache_pkg::way_idx_t                     wr_way;
    icache_pkg::offset_t                      wr_offset;
    icache_pkg::word_t                        wr_data;
    logic                                     touch;
    logic                                     tag_wr_en;
    logic                                     data_wr_en;

    // during a refill the read index holds the miss set, so it doubles as write index
    icache_tag_array u_tag_array (
        .clk        (clk),
        .rst        (rst),
        .rd_index   (rd_index),
        .lookup_tag (lookup_tag),
        .wr_en      (tag_wr_en),
        .wr_way     (wr_way),
        .wr_index   (rd_index),
        .wr_tag     (lookup_tag),
        .hit_way    (hit_way)
    );

    icache_data_array u_data_array (
        .clk       (clk),
        .rd_index  (rd_index),
        .rd_offset (rd_offset),
        .wr_en     (data_wr_en),
        .wr_way    (wr_way),
        .wr_index  (rd_index),
        .wr_offset (wr_offset),
        .wr_data   (wr_data),
        .rd_word   (way_words)
    );

    icache_plru u_plru (
        .clk       (clk),
        .rst       (rst),
        .index     (rd_index),
        .touch     (touch),
        .touch_way (touch_way),
        .victim    (victim)
    );

    icache_ctrl u_ctrl (
        .clk           (clk),
        .rst           (rst),
        .fetch_req     (fetch_req),
        .fetch_addr    (fetch_addr),
        .fetch_ready   (fetch_ready),
        .fetch_data_ok (fetch_data_ok),
        .fetch_rdata   (fetch_rdata),
        .ar            (ar),
        .ar_valid      (ar_valid),
        .ar_ready      (ar_ready),
        .r             (r),
        .r_valid       (r_valid),
        .rd_index      (rd_index),
        .rd_offset     (rd_offset),
        .lookup_tag    (lookup_tag),
        .hit_way       (hit_way),
        .way_words     (way_words),
        .victim        (victim),
        .touch         (touch),
        .touch_way     (touch_way),
        .tag_wr_en     (tag_wr_en),
        .data_wr_en    (data_wr_en),
        .wr_way        (wr_way),
        .wr_offset     (wr_offset),
        .wr_data       (wr_data)
    );

endmodule

// File: tb_icache_tests.svh
// drive one request and wait for its answer
task automatic fetch(input icache_pkg::addr_t a, output icache_pkg::word_t data,
                     output int lat);
    int n;
    data       = '0;
    lat        = 0;
    fetch_req  = 1'b1;
    fetch_addr = a;
    n          = 0;
    @(negedge clk);
    while (fetch_ready !== 1'b1 && n < TIMEOUT) begin
        @(negedge clk);
        n++;
    end
    if (fetch_ready !== 1'b1) begin
        $display("ERROR: fetch at %h was never accepted", a);
        hung = 1'b1;
        return;
    end
    @(posedge clk);
    #1;
    fetch_req = 1'b0;
    n         = 0;
    @(negedge clk);
    lat = 1;
    while (fetch_data_ok !== 1'b1 && n < TIMEOUT) begin
        @(negedge clk);
        lat++;
        n++;
    end
    if (fetch_data_ok !== 1'b1) begin
        $display("ERROR: fetch at %h got no answer", a);
        hung = 1'b1;
        return;
    end
    data = fetch_rdata;
    @(posedge clk);
    #1;
endtask

// fetch and check data plus the AR traffic the reference expects
task automatic fetch_check(input icache_pkg::addr_t a, output int way);
    icache_pkg::word_t data;
    icache_pkg::addr_t p;
    int                lat;
    int                n_ar;
    bit                uncached;
    way = -1;
    if (hung) return;
    uncached = (a[31:29] == 3'b101);
    if (!uncached) begin
        way = ref_access(a);
    end
    p    = phys_addr(a);
    n_ar = ar_addr_log.size();
    fetch(a, data, lat);
    if (hung) return;
    check($sformatf("word at %h", a), data, mem_word(p));
    if (uncached || way >= 0) begin
        check($sformatf("AR count for %h", a), ar_addr_log.size() - n_ar, 1);
        if (ar_addr_log.size() > n_ar) begin
            check("AR address", ar_addr_log[n_ar], uncached ? p : {p[31:5], 5'd0});
            check("AR length", ar_len_log[n_ar], uncached ? 0 : 7);
        end
    end else begin
        check($sformatf("AR count for %h", a), ar_addr_log.size() - n_ar, 0);
        check($sformatf("hit latency at %h", a), lat, 1);
    end
endtask

task automatic reset_and_miss();
    int way;
    @(negedge clk);
    check("fetch_ready after reset", fetch_ready, 1);
    check("ar_valid after reset", ar_valid, 0);
    check("fetch_data_ok after reset", fetch_data_ok, 0);
    @(posedge clk);
    #1;
    fetch_check(32'h0000_1234, way);
endtask

task automatic same_line_hits();
    int way;
    for (int w = 0; w < icache_pkg::LINE_WORDS; w++) begin
        if (w != 5) begin
            fetch_check(32'h0000_1220 + 4 * w, way);
        end
    end
endtask

task automatic segment_mapping();
    int way;
    fetch_check(32'hA000_0100, way);
    fetch_check(32'hA000_0100, way);
    fetch_check(32'h8000_0200, way);
endtask

// tags A to E all in set 0x15
task automatic tree_replacement();
    icache_pkg::addr_t a [5];
    int                way;
    for (int i = 0; i < 5; i++) begin
        a[i] = {20'(20'h00300 + i), 7'h15, 5'd0};
    end
    // fill order 0 2 1 3 is the bit-reversed count, E lands on A
    for (int i = 0; i < 5; i++) begin
        fetch_check(a[i], way);
        check("fill way", dut.wr_way, {i[0], i[1]});
    end
    for (int i = 1; i < 4; i++) begin
        fetch_check(a[i], way);
    end
    fetch_check(a[0], way);
    check("A refetch fills way 0", dut.wr_way, 0);
endtask

// 40 back-to-back fetches over 3 sets and 6 tags
task automatic random_stream();
    icache_pkg::addr_t addrs[$];
    icache_pkg::tag_t  tag;
    int                s;
    int                t;
    int                misses;
    int                n_ar;
    int                sent;
    int                answered;
    int                cycles;
    if (hung) return;
    misses = 0;
    for (int i = 0; i < 40; i++) begin
        s   = lfsr_bits(4) % 3;
        t   = lfsr_bits(4) % 6;
        // tags 4 and 5 sit in kseg0
        tag = (t >= 4) ? 20'h80120 + 20'(t) : 20'h00120 + 20'(t);
        addrs.push_back({tag, 7'(7'h40 + s), 3'(lfsr_bits(3)), 2'b00});
        if (ref_access(addrs[i]) >= 0) begin
            misses++;
        end
    end
    n_ar     = ar_addr_log.size();
    sent     = 0;
    answered = 0;
    cycles   = 0;
    while (answered < 40 && cycles < 40 * TIMEOUT) begin
        fetch_req  = (sent < 40);
        fetch_addr = (sent < 40) ? addrs[sent] : '0;
        @(negedge clk);
        if (fetch_data_ok === 1'b1) begin
            if (answered < sent) begin
                check($sformatf("stream word %0d", answered), fetch_rdata,
                      mem_word(phys_addr(addrs[answered])));
            end else begin
                errors++;
                $display("ERROR: answer with no request outstanding");
            end
            answered++;
        end
        if (fetch_req && fetch_ready === 1'b1) begin
            sent++;
        end
        @(posedge clk);
        #1;
        cycles++;
    end
    fetch_req = 1'b0;
    if (answered < 40) begin
        $display("ERROR: stream stalled after %0d of 40 answers", answered);
        hung = 1'b1;
    end else begin
        check("stream AR count", ar_addr_log.size() - n_ar, misses);
    end
endtask

// File: tb_icache.sv
module tb_icache;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int TIMEOUT = 100;

    logic                clk;
    logic                rst;
    logic                fetch_req;
    icache_pkg::addr_t   fetch_addr;
    logic                fetch_ready;
    logic                fetch_data_ok;
    icache_pkg::word_t   fetch_rdata;
    icache_pkg::ar_req_t ar;
    logic                ar_valid;
    logic                ar_ready;
    icache_pkg::r_beat_t r;
    logic                r_valid;

    logic [31:0] lfsr = 32'heacc_0768;
    int          errors;
    int          checks;
    int          err_mark;
    int          tests_run;
    int          tests_failed;
    bit          hung;

    // every AR seen on the bus
    icache_pkg::addr_t ar_addr_log[$];
    logic [7:0]        ar_len_log[$];

    // reference tags and tree bits
    icache_pkg::tag_t ref_tag [icache_pkg::SETS][icache_pkg::WAYS];
    bit               ref_valid [icache_pkg::SETS][icache_pkg::WAYS];
    bit               ref_root [icache_pkg::SETS];
    bit               ref_leaf [icache_pkg::SETS][2];

    icache_top dut (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // galois lfsr, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'h8020_0003 : lfsr >> 1;
        end
        return v;
    endfunction

    // segments 100 and 101 lose their top three bits
    function automatic icache_pkg::addr_t phys_addr(input icache_pkg::addr_t a);
        return (a[31:30] == 2'b10) ? {3'b000, a[28:0]} : a;
    endfunction

    function automatic icache_pkg::word_t mem_word(input icache_pkg::addr_t p);
        return p ^ 32'h5a5a_0000;
    endfunction

    task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
        end
    endtask

    // returns the filled way on a miss, -1 on a hit
    function automatic int ref_access(input icache_pkg::addr_t a);
        int set;
        int way;
        set = a[11:5];
        way = -1;
        for (int w = 0; w < icache_pkg::WAYS; w++) begin
            if (ref_valid[set][w] && ref_tag[set][w] == a[31:12]) begin
                way = w;
            end
        end
        ref_access = -1;
        if (way < 0) begin
            // root picks the pair, the pair's leaf picks the way
            way = ref_root[set] ? 2 + ref_leaf[set][1] : ref_leaf[set][0];
            ref_valid[set][way] = 1'b1;
            ref_tag[set][way]   = a[31:12];
            ref_access          = way;
        end
        // touch points both levels away from the way
        ref_root[set]          = (way < 2);
        ref_leaf[set][way / 2] = (way % 2 == 0);
    endfunction

    task automatic test_done(input string name);
        tests_run++;
        if (errors != err_mark || hung) begin
            tests_failed++;
            $display("%s: failed", name);
        end else begin
            $display("%s: passed", name);
        end
        err_mark = errors;
    endtask

    // bus memory, random AR delay and beat gaps
    initial begin
        icache_pkg::addr_t base;
        logic [7:0]        len;
        int                delay;
        ar_ready = 1'b0;
        r_valid  = 1'b0;
        r        = '0;
        forever begin
            @(posedge clk);
            #1;
            if (!rst && ar_valid === 1'b1) begin
                base = ar.addr;
                len  = ar.len;
                ar_addr_log.push_back(base);
                ar_len_log.push_back(len);
                delay = lfsr_bits(2);
                repeat (delay) begin
                    @(posedge clk);
                    #1;
                end
                ar_ready = 1'b1;
                @(posedge clk);
                #1;
                ar_ready = 1'b0;
                for (int b = 0; b <= len; b++) begin
                    if (lfsr_bits(1)) begin
                        r_valid = 1'b0;
                        @(posedge clk);
                        #1;
                    end
                    r_valid = 1'b1;
                    r.data  = mem_word(base + 4 * b);
                    r.last  = (b == len);
                    @(posedge clk);
                    #1;
                end
                r_valid = 1'b0;
                r.last  = 1'b0;
            end
        end
    end

    `include "tb_icache_tests.svh"

    initial begin
        rst        = 1'b1;
        fetch_req  = 1'b0;
        fetch_addr = '0;
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;
        reset_and_miss();
        test_done("reset and first miss");
        same_line_hits();
        test_done("same line hits");
        segment_mapping();
        test_done("segment mapping");
        tree_replacement();
        test_done("tree replacement");
        random_stream();
        test_done("random stream");
        $display("tests run %0d, failed %0d, checks %0d, mismatches %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0 && !hung) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// File: files.f
+incdir+.
icache_pkg.sv
icache_tag_array.sv
icache_data_array.sv
icache_plru.sv
icache_ctrl.sv
icache_top.sv
tb_icache.sv

// File: Bender.yml
package:
  name: icache

sources:
  - icache_pkg.sv
  - icache_tag_array.sv
  - icache_data_array.sv
  - icache_plru.sv
  - icache_ctrl.sv
  - icache_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_icache.sv
